/* Bender.yml */
package:
  name: mem_subsys

sources:
  - logic/bus_pkg.sv
  - logic/core_pkg.sv
  - logic/axi_lite_if.sv
  - logic/ifu_axi_fetch.sv
  - logic/lsu_axi_port.sv
  - logic/axi_lite_arbiter.sv
  - logic/axi_lite_sram.sv
  - logic/mem_subsys_top.sv
  - target: test
    files:
      - verif/tb_mem_checks.sv
      - verif/tb_mem_subsys.sv

/* logic/axi_lite_arbiter.sv */
module axi_lite_arbiter (
    input  logic       clk,
    input  logic       rst,
    axi_lite_if.slave  ifu,
    axi_lite_if.slave  lsu,
    axi_lite_if.master mem
);
    import core_pkg::*;

    logic locked;
    logic grant;
    logic last_served;
    logic ifu_req;
    logic lsu_req;
    logic winner;
    logic sel;
    logic sel_ifu;
    logic sel_lsu;
    logic addr_fire;
    logic resp_fire;

    assign ifu_req = ifu.arvalid || ifu.awvalid;
    assign lsu_req = lsu.arvalid || lsu.awvalid;

    // On a tie the master not served last wins
    always_comb begin
        if (ifu_req && lsu_req) begin
            winner = (last_served == mst_ifu) ? mst_lsu : mst_ifu;
        end else if (lsu_req) begin
            winner = mst_lsu;
        end else begin
            winner = mst_ifu;
        end
    end

    assign sel     = locked ? grant : winner;
    assign sel_ifu = (sel == mst_ifu);
    assign sel_lsu = (sel == mst_lsu);

    // Request side, open only while nothing is in flight
    assign mem.awaddr  = sel_lsu ? lsu.awaddr : ifu.awaddr;
    assign mem.awvalid = !locked && (sel_lsu ? lsu.awvalid : ifu.awvalid);
    assign mem.wdata   = sel_lsu ? lsu.wdata : ifu.wdata;
    assign mem.wstrb   = sel_lsu ? lsu.wstrb : ifu.wstrb;
    assign mem.wvalid  = !locked && (sel_lsu ? lsu.wvalid : ifu.wvalid);
    assign mem.araddr  = sel_lsu ? lsu.araddr : ifu.araddr;
    assign mem.arvalid = !locked && (sel_lsu ? lsu.arvalid : ifu.arvalid);
    assign mem.bready  = locked && (sel_lsu ? lsu.bready : ifu.bready);
    assign mem.rready  = locked && (sel_lsu ? lsu.rready : ifu.rready);

    assign ifu.awready = !locked && sel_ifu && mem.awready;
    assign ifu.wready  = !locked && sel_ifu && mem.wready;
    assign ifu.arready = !locked && sel_ifu && mem.arready;
    assign lsu.awready = !locked && sel_lsu && mem.awready;
    assign lsu.wready  = !locked && sel_lsu && mem.wready;
    assign lsu.arready = !locked && sel_lsu && mem.arready;

    // Response payload is shared, valids go to the owner only
    assign ifu.bresp  = mem.bresp;
    assign ifu.bvalid = locked && sel_ifu && mem.bvalid;
    assign ifu.rdata  = mem.rdata;
    assign ifu.rresp  = mem.rresp;
    assign ifu.rvalid = locked && sel_ifu && mem.rvalid;
    assign lsu.bresp  = mem.bresp;
    assign lsu.bvalid = locked && sel_lsu && mem.bvalid;
    assign lsu.rdata  = mem.rdata;
    assign lsu.rresp  = mem.rresp;
    assign lsu.rvalid = locked && sel_lsu && mem.rvalid;

    assign addr_fire = (mem.arvalid && mem.arready)
                     || (mem.awvalid && mem.awready && mem.wvalid && mem.wready);
    assign resp_fire = (mem.rvalid && mem.rready) || (mem.bvalid && mem.bready);

    // Grant locked from address transfer to response transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            locked      <= 1'b0;
            grant       <= mst_ifu;
            last_served <= mst_lsu;
        end else if (addr_fire) begin
            locked      <= 1'b1;
            grant       <= winner;
            last_served <= winner;
        end else if (resp_fire) begin
            locked      <= 1'b0;
        end
    end

endmodule

/* logic/axi_lite_if.sv */
interface axi_lite_if;
    import bus_pkg::*;

    // Write address
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;

    // Write data
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;

    // Write response
    resp_t                 bresp;
    logic                  bvalid;
    logic                  bready;

    // Read address
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;

    // Read data
    rdata_u                rdata;
    resp_t                 rresp;
    logic                  rvalid;
    logic                  rready;

    modport master (
        output awaddr, awvalid, input awready,
        output wdata, wstrb, wvalid, input wready,
        input bresp, bvalid, output bready,
        output araddr, arvalid, input arready,
        input rdata, rresp, rvalid, output rready
    );

    modport slave (
        input awaddr, awvalid, output awready,
        input wdata, wstrb, wvalid, output wready,
        output bresp, bvalid, input bready,
        input araddr, arvalid, output arready,
        output rdata, rresp, rvalid, input rready
    );

endinterface

/* logic/axi_lite_sram.sv */
module axi_lite_sram #(
    parameter int mem_words = 256
) (
    input  logic      clk,
    input  logic      rst,
    axi_lite_if.slave bus
);
    import bus_pkg::*;

    localparam int idx_width = $clog2(mem_words);
    localparam logic [addr_width-1:0] byte_limit = addr_width'(mem_words * 8);

    logic [data_width-1:0] mem [mem_words];

    logic                  rvalid_q;
    logic                  bvalid_q;
    rdata_u                rdata_q;
    resp_t                 rresp_q;
    resp_t                 bresp_q;
    logic                  idle;
    logic                  ar_fire;
    logic                  aw_fire;
    logic                  ar_in_range;
    logic                  aw_in_range;
    logic [idx_width-1:0]  ridx;
    logic [idx_width-1:0]  widx;

    // One transaction at a time
    assign idle        = !rvalid_q && !bvalid_q;
    assign bus.arready = idle;
    // Write taken only with address and data both present
    assign bus.awready = idle && bus.awvalid && bus.wvalid;
    assign bus.wready  = idle && bus.awvalid && bus.wvalid;

    assign ar_fire     = bus.arvalid && bus.arready;
    assign aw_fire     = bus.awvalid && bus.awready;
    assign ar_in_range = (bus.araddr < byte_limit);
    assign aw_in_range = (bus.awaddr < byte_limit);
    assign ridx        = bus.araddr[idx_width+2:3];
    assign widx        = bus.awaddr[idx_width+2:3];

    // Byte lanes under strobe, out-of-range writes dropped
    always_ff @(posedge clk) begin
        if (aw_fire && aw_in_range) begin
            for (int b = 0; b < strb_width; b++) begin
                if (bus.wstrb[b]) begin
                    mem[widx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata_q.dword <= ar_in_range ? mem[ridx] : '0;
            rresp_q       <= ar_in_range ? resp_okay : resp_slverr;
        end
        if (aw_fire) begin
            bresp_q <= aw_in_range ? resp_okay : resp_slverr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (ar_fire) begin
                rvalid_q <= 1'b1;
            end else if (bus.rready) begin
                rvalid_q <= 1'b0;
            end
            if (aw_fire) begin
                bvalid_q <= 1'b1;
            end else if (bus.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;
    assign bus.rresp  = rresp_q;
    assign bus.bvalid = bvalid_q;
    assign bus.bresp  = bresp_q;

endmodule

/* logic/bus_pkg.sv */
package bus_pkg;

    // Bus geometry
    localparam int addr_width = 32;
    localparam int data_width = 64;
    localparam int strb_width = data_width / 8;

    // Response code, only okay and slverr are produced
    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // One read word, seen as a doubleword by loads
    // and as a pair of instructions by the fetch unit
    typedef union packed {
        logic [data_width-1:0] dword;
        logic [1:0][31:0]      insn;
    } rdata_u;

endpackage

/* logic/core_pkg.sv */
package core_pkg;

    // Register and pc width
    localparam int xlen = 64;

    // Arbiter master indices
    localparam logic mst_ifu = 1'b0;
    localparam logic mst_lsu = 1'b1;

    // SRAM depth in 64-bit words
    localparam int mem_words_default = 256;

endpackage

/* logic/ifu_axi_fetch.sv */
module ifu_axi_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pc_valid,
    output logic                      pc_ready,
    input  logic [core_pkg::xlen-1:0] pc,
    output logic                      inst_valid,
    output logic                      inst_ready,
    output logic [31:0]               inst,
    output logic                      inst_fault,
    axi_lite_if.master                bus
);
    import bus_pkg::*;

    logic outstanding;
    logic half_q;
    logic issue_ok;

    // Fetch never writes
    assign bus.awaddr  = '0;
    assign bus.awvalid = 1'b0;
    assign bus.wdata   = '0;
    assign bus.wstrb   = '0;
    assign bus.wvalid  = 1'b0;
    assign bus.bready  = 1'b0;

    // New fetch only after the previous instruction was taken
    assign issue_ok    = !outstanding && inst_ready;
    assign bus.araddr  = pc[addr_width-1:0];
    assign bus.arvalid = pc_valid && issue_ok;
    assign pc_ready    = bus.arready && issue_ok;

    // Pick the 32-bit half addressed by pc bit 2
    assign inst        = bus.rdata.insn[half_q];
    assign inst_fault  = (bus.rresp == resp_slverr);
    assign inst_valid  = bus.rvalid;
    assign bus.rready  = inst_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (bus.arvalid && bus.arready) begin
            outstanding <= 1'b1;
        end else if (bus.rvalid && bus.rready) begin
            outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready) begin
            half_q <= pc[2];
        end
    end

    // Drops for one cycle after each instruction transfer
    always_ff @(posedge clk) begin
        if (rst) begin
            inst_ready <= 1'b0;
        end else if (inst_valid && inst_ready) begin
            inst_ready <= 1'b0;
        end else begin
            inst_ready <= 1'b1;
        end
    end

endmodule

/* logic/lsu_axi_port.sv */
module lsu_axi_port (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  logic [bus_pkg::addr_width-1:0] req_addr,
    input  logic [core_pkg::xlen-1:0]      req_wdata,
    input  logic [bus_pkg::strb_width-1:0] req_wstrb,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic [core_pkg::xlen-1:0]      rsp_rdata,
    output logic                           rsp_err,
    axi_lite_if.master                     bus
);
    import bus_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;
    localparam logic [1:0] st_hold = 2'd3;

    logic [1:0]            state;
    logic [1:0]            state_next;
    logic                  write_q;
    logic [addr_width-1:0] addr_q;
    logic [data_width-1:0] wdata_q;
    logic [strb_width-1:0] wstrb_q;
    logic                  addr_done;
    logic                  resp_done;

    // AW and W always complete together
    assign addr_done = write_q ? (bus.awready && bus.wready) : bus.arready;
    assign resp_done = write_q ? bus.bvalid : bus.rvalid;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_valid && req_ready) begin
                    state_next = st_addr;
                end
            end
            st_addr: begin
                if (addr_done) begin
                    state_next = st_wait;
                end
            end
            st_wait: begin
                if (resp_done) begin
                    state_next = st_hold;
                end
            end
            default: begin
                if (rsp_ready) begin
                    state_next = st_idle;
                end
            end
        endcase
    end

    // req_ready is registered so it stays low through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            req_ready <= 1'b0;
        end else begin
            state     <= state_next;
            req_ready <= (state_next == st_idle);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            write_q <= req_write;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
        // Response kept here while the core back-pressures
        if (state == st_wait && resp_done) begin
            if (write_q) begin
                rsp_err   <= (bus.bresp == resp_slverr);
                rsp_rdata <= '0;
            end else begin
                rsp_err   <= (bus.rresp == resp_slverr);
                rsp_rdata <= bus.rdata.dword;
            end
        end
    end

    assign bus.awaddr  = addr_q;
    assign bus.awvalid = (state == st_addr) && write_q;
    assign bus.wdata   = wdata_q;
    assign bus.wstrb   = wstrb_q;
    assign bus.wvalid  = (state == st_addr) && write_q;
    assign bus.bready  = (state == st_wait) && write_q;
    assign bus.araddr  = addr_q;
    assign bus.arvalid = (state == st_addr) && !write_q;
    assign bus.rready  = (state == st_wait) && !write_q;

    assign rsp_valid   = (state == st_hold);

endmodule

/* logic/mem_subsys_top.sv */
module mem_subsys_top #(
    parameter int mem_words = core_pkg::mem_words_default
) (
    input  logic                           clk,
    input  logic                           rst,
    // Instruction fetch
    input  logic                           pc_valid,
    output logic                           pc_ready,
    input  logic [core_pkg::xlen-1:0]      pc,
    output logic                           inst_valid,
    output logic                           inst_ready,
    output logic [31:0]                    inst,
    output logic                           inst_fault,
    // Load/store
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  logic [bus_pkg::addr_width-1:0] req_addr,
    input  logic [core_pkg::xlen-1:0]      req_wdata,
    input  logic [bus_pkg::strb_width-1:0] req_wstrb,
    output logic                           rsp_valid,
    input  logic                           rsp_ready,
    output logic [core_pkg::xlen-1:0]      rsp_rdata,
    output logic                           rsp_err
);

    axi_lite_if ifu_bus ();
    axi_lite_if lsu_bus ();
    axi_lite_if mem_bus ();

    ifu_axi_fetch i_ifu (
        .clk        (clk),
        .rst        (rst),
        .pc_valid   (pc_valid),
        .pc_ready   (pc_ready),
        .pc         (pc),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .inst_fault (inst_fault),
        .bus        (ifu_bus.master)
    );

    lsu_axi_port i_lsu (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wstrb (req_wstrb),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .bus       (lsu_bus.master)
    );

    // Fetch and load/store share the one SRAM port
    axi_lite_arbiter i_arbiter (
        .clk (clk),
        .rst (rst),
        .ifu (ifu_bus.slave),
        .lsu (lsu_bus.slave),
        .mem (mem_bus.master)
    );

    axi_lite_sram #(
        .mem_words (mem_words)
    ) i_sram (
        .clk (clk),
        .rst (rst),
        .bus (mem_bus.slave)
    );

endmodule

/* tb.f */
logic/bus_pkg.sv
logic/core_pkg.sv
logic/axi_lite_if.sv
logic/ifu_axi_fetch.sv
logic/lsu_axi_port.sv
logic/axi_lite_arbiter.sv
logic/axi_lite_sram.sv
logic/mem_subsys_top.sv
verif/tb_mem_checks.sv
verif/tb_mem_subsys.sv

/* verif/tb_mem_checks.sv */
module tb_mem_checks (
    input  logic        clk,
    input  logic        rst,
    input  logic        pc_valid,
    input  logic        pc_ready,
    input  logic        inst_valid,
    input  logic        inst_ready,
    input  logic        req_valid,
    input  logic        req_ready,
    input  logic        rsp_valid,
    input  logic        rsp_ready,
    input  logic [63:0] rsp_rdata,
    input  logic        rsp_err,
    output logic        failed
);
    timeunit 1ns;
    timeprecision 1ps;

    int          rst_edges;
    int          run_edges;
    logic        held;
    logic [63:0] held_rdata;
    logic        held_err;
    logic        lsu_busy;
    int          lsu_seen_by_fetch;
    int          fetch_seen_by_lsu;

    initial begin
        failed            = 1'b0;
        rst_edges         = 0;
        run_edges         = 0;
        held              = 1'b0;
        lsu_busy          = 1'b0;
        lsu_seen_by_fetch = 0;
        fetch_seen_by_lsu = 0;
    end

    task automatic raise_failure(input string msg);
        if (!failed) begin
            $display("%s", msg);
            failed = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            // Outputs are settled after the first reset edge
            if (rst_edges > 0) begin
                assert (!pc_ready && !req_ready && !inst_valid && !rsp_valid)
                else raise_failure($sformatf("ERROR %0t: handshake output high in reset",
                                             $time));
            end
            rst_edges++;
            run_edges = 0;
            held      = 1'b0;
            lsu_busy  = 1'b0;
        end else begin
            if (run_edges == 1) begin
                assert (inst_ready)
                else raise_failure($sformatf("ERROR %0t: inst_ready still low after reset",
                                             $time));
            end
            run_edges++;

            // Response frozen while the core holds rsp_ready low
            if (held) begin
                assert (rsp_valid && rsp_rdata === held_rdata && rsp_err === held_err)
                else raise_failure($sformatf("ERROR %0t: response changed under back-pressure",
                                             $time));
            end
            held       = rsp_valid && !rsp_ready;
            held_rdata = rsp_rdata;
            held_err   = rsp_err;
            assert (!(rsp_valid && req_ready))
            else raise_failure($sformatf("ERROR %0t: req_ready high with a pending response",
                                         $time));

            // Round robin bounds the wait of each master
            if (pc_valid && !pc_ready) begin
                if (rsp_valid && rsp_ready) begin
                    lsu_seen_by_fetch++;
                end
            end else begin
                lsu_seen_by_fetch = 0;
            end
            assert (lsu_seen_by_fetch <= 2)
            else raise_failure("A fetch waited behind more than two load/store transactions");

            if (req_valid && req_ready) begin
                lsu_busy          = 1'b1;
                fetch_seen_by_lsu = 0;
            end else if (rsp_valid) begin
                lsu_busy = 1'b0;
            end else if (lsu_busy && inst_valid && inst_ready) begin
                fetch_seen_by_lsu++;
            end
            assert (fetch_seen_by_lsu <= 2)
            else raise_failure("A load/store waited behind more than two fetches");
        end
    end

endmodule

/* verif/tb_mem_subsys.sv */
module tb_mem_subsys;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 40;
    localparam logic [15:0] lfsr_seed = 16'd49177;
    localparam logic [31:0] mem_bytes = 32'd2048;

    // Test lengths, also used for the watchdog
    localparam int n_words = 16;
    localparam int n_oor   = 4;
    localparam int n_pairs = 8;
    localparam int n_stall = 8;
    localparam int num_ops = 4 * n_words + 4 * n_oor + 6 * n_pairs + n_stall;
    localparam int wd_ns   = num_ops * 40 * clk_period + 4 * clk_period;

    logic        clk;
    logic        rst;
    logic        pc_valid;
    logic        pc_ready;
    logic [63:0] pc;
    logic        inst_valid;
    logic        inst_ready;
    logic [31:0] inst;
    logic        inst_fault;
    logic        req_valid;
    logic        req_ready;
    logic        req_write;
    logic [31:0] req_addr;
    logic [63:0] req_wdata;
    logic [7:0]  req_wstrb;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [63:0] rsp_rdata;
    logic        rsp_err;
    logic        chk_failed;

    logic [15:0] lfsr;
    logic [63:0] shadow [256];
    logic [31:0] addr_list [n_words];

    mem_subsys_top #(
        .mem_words (256)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .pc_valid   (pc_valid),
        .pc_ready   (pc_ready),
        .pc         (pc),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst       (inst),
        .inst_fault (inst_fault),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wstrb  (req_wstrb),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err)
    );

    tb_mem_checks i_checks (
        .clk        (clk),
        .rst        (rst),
        .pc_valid   (pc_valid),
        .pc_ready   (pc_ready),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_rdata  (rsp_rdata),
        .rsp_err    (rsp_err),
        .failed     (chk_failed)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic end_run(input bit ok);
        if (ok) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "Run stopped at the first failure");
        end
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
        end_run(1'b0);
    endtask

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    task automatic lsu_op(input logic wr, input logic [31:0] addr, input logic [63:0] data,
                          input logic [7:0] strb, input int stall);
        logic        exp_err;
        logic [63:0] exp_data;
        exp_err  = (addr >= mem_bytes);
        exp_data = (wr || exp_err) ? 64'd0 : shadow[addr[10:3]];
        @(negedge clk);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        rsp_ready = (stall == 0);
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        // Back-pressure starts once the response shows
        if (stall > 0) begin
            while (!rsp_valid) @(negedge clk);
            repeat (stall) @(negedge clk);
            rsp_ready = 1'b1;
        end
        @(posedge clk);
        while (!(rsp_valid && rsp_ready)) @(posedge clk);
        assert (rsp_rdata === exp_data)
        else report_mismatch("rsp_rdata", rsp_rdata, exp_data);
        assert (rsp_err === exp_err)
        else report_mismatch("rsp_err", {63'd0, rsp_err}, {63'd0, exp_err});
        if (wr && !exp_err) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    shadow[addr[10:3]][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
    endtask

    task automatic fetch_op(input logic [31:0] addr);
        logic        exp_fault;
        logic [63:0] word;
        logic [31:0] exp_inst;
        exp_fault = (addr >= mem_bytes);
        word      = exp_fault ? 64'd0 : shadow[addr[10:3]];
        exp_inst  = addr[2] ? word[63:32] : word[31:0];
        @(negedge clk);
        pc_valid = 1'b1;
        pc       = {32'd0, addr};
        @(posedge clk);
        while (!pc_ready) @(posedge clk);
        @(negedge clk);
        pc_valid = 1'b0;
        @(posedge clk);
        while (!(inst_valid && inst_ready)) @(posedge clk);
        assert (inst === exp_inst)
        else report_mismatch("inst", {32'd0, inst}, {32'd0, exp_inst});
        assert (inst_fault === exp_fault)
        else report_mismatch("inst_fault", {63'd0, inst_fault}, {63'd0, exp_fault});
    endtask

    always @(posedge chk_failed) begin
        end_run(1'b0);
    end

    initial begin
        #(wd_ns);
        $display("Watchdog expired before all tests completed");
        end_run(1'b0);
    end

    initial begin
        logic [63:0] r;
        logic [63:0] s;
        logic [63:0] t;
        logic [31:0] a;
        lfsr      = lfsr_seed;
        clk       = 1'b0;
        rst       = 1'b1;
        pc_valid  = 1'b0;
        pc        = '0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        rsp_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Low index bits make every test address a distinct word
        for (int i = 0; i < n_words; i++) begin
            r = rand_bits(4);
            addr_list[i] = {21'd0, r[3:0], i[3:0], 3'd0};
        end
        // Full words first so no byte stays unknown
        for (int i = 0; i < n_words; i++) begin
            lsu_op(1'b1, addr_list[i], rand_bits(64), 8'hff, 0);
        end
        for (int i = 0; i < n_words; i++) begin
            r = rand_bits(8);
            lsu_op(1'b1, addr_list[i], rand_bits(64), r[7:0], 0);
        end
        for (int i = 0; i < n_words; i++) begin
            lsu_op(1'b0, addr_list[i], 64'd0, 8'd0, 0);
        end
        for (int i = 0; i < n_words; i++) begin
            r = rand_bits(1);
            fetch_op(addr_list[i] | {29'd0, r[0], 2'd0});
        end

        // Out of range, aliasing a written word in the low bits
        for (int k = 0; k < n_oor; k++) begin
            r = rand_bits(20);
            a = {r[19:0], 1'b1, addr_list[k][10:0]};
            lsu_op(1'b1, a, rand_bits(64), 8'hff, 0);
            lsu_op(1'b0, a, 64'd0, 8'd0, 0);
            fetch_op(a);
            lsu_op(1'b0, addr_list[k], 64'd0, 8'd0, 0);
        end

        // Both masters keep requesting so each one has to wait its turn
        for (int p = 0; p < n_pairs; p++) begin
            r = rand_bits(64);
            s = rand_bits(9);
            t = rand_bits(64);
            fork
                begin
                    for (int j = 0; j < 3; j++) begin
                        fetch_op(addr_list[p] | {29'd0, s[8], 2'd0});
                    end
                end
                begin
                    lsu_op(1'b1, addr_list[p + n_pairs], r, s[7:0], 0);
                    lsu_op(1'b0, addr_list[p + n_pairs], 64'd0, 8'd0, 0);
                    lsu_op(p[0], addr_list[p + n_pairs], t, 8'hff, 0);
                end
            join
        end

        for (int k = 0; k < n_stall; k++) begin
            r = rand_bits(4);
            s = rand_bits(8);
            lsu_op(k[0], addr_list[k], rand_bits(64), s[7:0], 1 + int'(r[3:0]));
        end

        repeat (2) @(negedge clk);
        end_run(!chk_failed);
    end

endmodule
